// File: verilog/ppu_regs_pkg.sv
`default_nettype none

// LCD control registers and scanline timing shared by the timer and fetcher
package ppu_regs_pkg;

  // Register set as seen by the background fetcher
  // lcdc bit 6 picks the tile map, bit 4 picks tile data addressing
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
  } lcd_regs_t;

  // PPU mode, encoded as in the STAT mode field
  typedef enum logic [1:0] {
    ppu_mode_0 = 2'd0,  // Horizontal blank
    ppu_mode_1 = 2'd1,  // Vertical blank
    ppu_mode_2 = 2'd2,  // OAM scan
    ppu_mode_3 = 2'd3   // Drawing
  } ppu_mode_t;

  // Dots in one scanline, all modes together
  localparam logic [8:0] dots_per_line = 9'd456;

  // OAM scan always lasts this many dots
  localparam logic [8:0] mode2_len = 9'd80;

  // Pixels that end the drawing phase
  localparam logic [7:0] screen_width = 8'd160;

  // Lines 0 to 143 are drawn
  localparam logic [7:0] visible_lines = 8'd144;

  // Lines 144 to 153 are vertical blank
  localparam logic [7:0] lines_per_frame = 8'd154;

endpackage

`default_nettype wire

// File: verilog/ppu_pixel_pkg.sv
`default_nettype none

// Pixel and VRAM access types for the background path
package ppu_pixel_pkg;

  // 2-bit colour number before any palette
  typedef logic [1:0] gb_color_t;

  // One pixel as it moves through the FIFO
  typedef struct packed {
    gb_color_t color;
    logic      valid;
  } pixel_t;

  // Eight pixels of one tile row, element 0 is the leftmost
  typedef pixel_t [7:0] pixel_row_t;

  // VRAM read request, addr is an offset into the 8 KiB window
  typedef struct packed {
    logic        read_req;
    logic [12:0] addr;
  } vram_req_t;

  // Tile map byte, read as unsigned or signed depending on LCDC bit 4
  typedef union packed {
    logic        [7:0] unsigned_id;
    logic signed [7:0] signed_id;
  } tile_entry_u;

  // Size of video RAM in bytes
  localparam int unsigned vram_bytes = 8192;

  // Tile maps, 32x32 entries each
  localparam logic [12:0] map0_base = 13'h1800;
  localparam logic [12:0] map1_base = 13'h1C00;

  // Tile data bases
  // data0 with unsigned ids, data1 is the centre of the signed range
  localparam logic [12:0] data0_base = 13'h0000;
  localparam logic [12:0] data1_base = 13'h1000;

endpackage

`default_nettype wire

// File: verilog/ppu_mode_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_mode_timer import ppu_regs_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       pixel_valid,
  output ppu_mode_t  mode,
  output logic [8:0] dot,
  output logic [7:0] ly,
  output logic       flush
);

  // Pixels emitted so far in this drawing phase
  logic [7:0] pix_count;
  logic       line_end;
  logic [7:0] next_ly;

  assign line_end = dot == dots_per_line - 9'd1;
  // Frame wraps after the last vertical blank line
  assign next_ly = (ly == lines_per_frame - 8'd1) ? 8'd0 : ly + 8'd1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode      <= ppu_mode_2;
      dot       <= '0;
      ly        <= '0;
      flush     <= 1'b0;
      pix_count <= '0;
    end else begin
      // High for dot 0 of the next line only
      flush <= line_end;
      if (line_end) begin
        dot  <= '0;
        ly   <= next_ly;
        mode <= (next_ly < visible_lines) ? ppu_mode_2 : ppu_mode_1;
      end else begin
        dot <= dot + 9'd1;
        if (mode == ppu_mode_2 && dot == mode2_len - 9'd1) begin
          // OAM scan done, drawing starts next dot
          mode      <= ppu_mode_3;
          pix_count <= '0;
        end else if (mode == ppu_mode_3 && pixel_valid) begin
          pix_count <= pix_count + 8'd1;
          // Drawing length varies, it ends on the last pixel strobe
          if (pix_count == screen_width - 8'd1) begin
            mode <= ppu_mode_0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/ppu_vram.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_vram import ppu_pixel_pkg::*; (
  input  logic        clk,
  input  logic        we,
  input  logic [12:0] waddr,
  input  logic [7:0]  wdata,
  input  vram_req_t   req,
  output logic [7:0]  rdata
);

  // Tile data at 0x0000-0x17FF, maps at 0x1800-0x1FFF
  logic [7:0] mem [vram_bytes];

  // Loaded from outside, no CPU arbitration here
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Combinational read off the registered address
  // Request made in phase 0 is valid through phase 1
  assign rdata = req.read_req ? mem[req.addr] : 8'h00;

endmodule

`default_nettype wire

// File: verilog/ppu_bg_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_bg_fetcher import ppu_regs_pkg::*, ppu_pixel_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  lcd_regs_t  regs,
  input  ppu_mode_t  mode,
  input  logic [8:0] dot,
  input  logic [7:0] ly,
  output vram_req_t  req,
  input  logic [7:0] rdata,
  input  logic       empty,
  output logic       push,
  output pixel_row_t row
);

  typedef enum logic [1:0] {
    fetch_get_tile,
    fetch_get_low,
    fetch_get_high,
    fetch_push
  } fetch_state_t;

  fetch_state_t state;
  // 0 issues the read, 1 latches the data
  logic         phase;
  // Tile column in the map, wraps at 32
  logic [4:0]   col;
  tile_entry_u  tile_id;
  logic [7:0]   tile_low;
  logic [7:0]   tile_high;

  logic [12:0]  map_base;
  logic [7:0]   map_y;
  logic [2:0]   fine_y;
  logic [12:0]  map_addr;
  logic [12:0]  id_offset;
  logic [12:0]  row_addr;

  assign map_base = regs.lcdc[6] ? map1_base : map0_base;
  // Background line, wraps at 256
  assign map_y    = regs.scy + ly;
  assign fine_y   = map_y[2:0];
  assign map_addr = map_base + {3'b000, map_y[7:3], 5'b00000} + {8'h00, col};

  // Tile id times 16, sign extended when addressing from data1_base
  assign id_offset = regs.lcdc[4] ? {1'b0, tile_id.unsigned_id, 4'b0000}
                                  : {tile_id.signed_id[7], tile_id.signed_id, 4'b0000};
  assign row_addr  = (regs.lcdc[4] ? data0_base : data1_base) + id_offset
                     + {9'h000, fine_y, 1'b0};

  // High byte gives colour bit 1, bit 7 is the leftmost pixel
  function automatic pixel_row_t build_row(input logic [7:0] lo, input logic [7:0] hi);
    pixel_row_t r;
    for (int i = 0; i < 8; i++) begin
      r[i].color = {hi[7-i], lo[7-i]};
      r[i].valid = 1'b1;
    end
    return r;
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= fetch_get_tile;
      phase        <= 1'b0;
      col          <= '0;
      tile_id      <= '0;
      tile_low     <= '0;
      tile_high    <= '0;
      push         <= 1'b0;
      row          <= '0;
      req          <= '0;
    end else if (flush) begin
      // Line start, drop any row left over from the previous line
      state        <= fetch_get_tile;
      phase        <= 1'b0;
      push         <= 1'b0;
      req.read_req <= 1'b0;
    end else if (mode == ppu_mode_2 && dot == mode2_len - 9'd1) begin
      // Coarse scroll only
      col <= regs.scx[7:3];
    end else if (mode == ppu_mode_3) begin
      push <= 1'b0;
      case (state)
        fetch_get_tile: begin
          if (!phase) begin
            req.addr     <= map_addr;
            req.read_req <= 1'b1;
          end else begin
            tile_id.unsigned_id <= rdata;
            req.read_req        <= 1'b0;
            state               <= fetch_get_low;
          end
          phase <= ~phase;
        end
        fetch_get_low: begin
          if (!phase) begin
            req.addr     <= row_addr;
            req.read_req <= 1'b1;
          end else begin
            tile_low     <= rdata;
            req.read_req <= 1'b0;
            state        <= fetch_get_high;
          end
          phase <= ~phase;
        end
        fetch_get_high: begin
          if (!phase) begin
            req.addr     <= row_addr + 13'd1;
            req.read_req <= 1'b1;
          end else begin
            tile_high    <= rdata;
            req.read_req <= 1'b0;
            state        <= fetch_push;
          end
          phase <= ~phase;
        end
        fetch_push: begin
          // Retry each dot until the FIFO has drained
          if (empty) begin
            row   <= build_row(tile_low, tile_high);
            push  <= 1'b1;
            col   <= col + 5'd1;
            state <= fetch_get_tile;
          end
        end
        default: state <= fetch_get_tile;
      endcase
    end else begin
      // Hold position, strobes stay low
      push         <= 1'b0;
      req.read_req <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ppu_bg_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_bg_fifo import ppu_regs_pkg::*, ppu_pixel_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  ppu_mode_t  mode,
  input  logic       push,
  input  pixel_row_t row,
  output logic       empty,
  output pixel_t     pixel
);

  // Element 0 is the next pixel out
  pixel_row_t buffer;
  // Pixels left, 0 to 8
  logic [3:0] count;
  logic       shift_out;

  assign empty     = count == 4'd0;
  // One pixel per drawing dot while anything is loaded
  assign shift_out = mode == ppu_mode_3 && !empty;

  assign pixel.color = buffer[0].color;
  assign pixel.valid = shift_out && buffer[0].valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else if (push) begin
      count <= 4'd8;
    end else if (shift_out) begin
      count <= count - 4'd1;
    end
  end

  // Pixel data, the count says what is live
  always_ff @(posedge clk) begin
    if (push) begin
      buffer <= row;
    end else if (shift_out) begin
      buffer <= {pixel_t'('0), buffer[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: verilog/ppu_bg_top.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_bg_top import ppu_regs_pkg::*, ppu_pixel_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  lcd_regs_t   regs,
  input  logic        vram_we,
  input  logic [12:0] vram_waddr,
  input  logic [7:0]  vram_wdata,
  output pixel_t      pixel,
  output ppu_mode_t   mode,
  output logic [7:0]  ly
);

  logic [8:0] dot;
  logic       flush;
  vram_req_t  fetch_req;
  logic [7:0] rdata;
  logic       push;
  pixel_row_t row;
  logic       empty;

  // Line and frame sequencing, counts FIFO output to end drawing
  ppu_mode_timer u_timer (
    .clk         (clk),
    .reset       (reset),
    .pixel_valid (pixel.valid),
    .mode        (mode),
    .dot         (dot),
    .ly          (ly),
    .flush       (flush)
  );

  ppu_vram u_vram (
    .clk   (clk),
    .we    (vram_we),
    .waddr (vram_waddr),
    .wdata (vram_wdata),
    .req   (fetch_req),
    .rdata (rdata)
  );

  ppu_bg_fetcher u_fetcher (
    .clk   (clk),
    .reset (reset),
    .flush (flush),
    .regs  (regs),
    .mode  (mode),
    .dot   (dot),
    .ly    (ly),
    .req   (fetch_req),
    .rdata (rdata),
    .empty (empty),
    .push  (push),
    .row   (row)
  );

  // Empty level is the only back-pressure to the fetcher
  ppu_bg_fifo u_fifo (
    .clk   (clk),
    .reset (reset),
    .flush (flush),
    .mode  (mode),
    .push  (push),
    .row   (row),
    .empty (empty),
    .pixel (pixel)
  );

endmodule

`default_nettype wire

// File: verification/ppu_bg_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Fetcher to FIFO and fetcher to VRAM rules
module ppu_bg_properties import ppu_regs_pkg::*, ppu_pixel_pkg::*; (
  input logic      clk,
  input logic      reset,
  input ppu_mode_t mode,
  input vram_req_t req,
  input logic      empty,
  input logic      push
);

  // Number of assertion failures that the testbench reads at the end of the run
  int unsigned fail_count = 0;

  // A row only goes into a drained FIFO
  push_when_empty: assert property (@(posedge clk) disable iff (reset) push |-> empty)
    else begin
      $error("push while the FIFO still holds pixels");
      fail_count++;
    end

  // Read strobe only high while drawing
  read_in_drawing: assert property (@(posedge clk) disable iff (reset)
    req.read_req |-> mode == ppu_mode_3)
    else begin
      $error("VRAM read issued outside the drawing phase");
      fail_count++;
    end

  // Three two-dot reads sit between any two pushes
  push_spacing: assert property (@(posedge clk) disable iff (reset) push |=> !push [*6])
    else begin
      $error("second push within six dots");
      fail_count++;
    end

endmodule

bind ppu_bg_fetcher ppu_bg_properties props (
  .clk   (clk),
  .reset (reset),
  .mode  (mode),
  .req   (req),
  .empty (empty),
  .push  (push)
);

`default_nettype wire

// File: verification/ppu_bg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_bg_tb import ppu_regs_pkg::*, ppu_pixel_pkg::*; ();

  // Register set plus the line to capture
  typedef struct packed {
    lcd_regs_t  regs;
    logic [7:0] line;
  } scenario_t;

  localparam int line_dots = 456;
  // Longest wait for a given line start
  localparam int frame_dots = line_dots * 155;

  // Columns are lcdc, scx, scy, captured line
  scenario_t scenarios [4] = '{
    {8'h10, 8'h00, 8'h00, 8'd5},
    {8'h40, 8'h00, 8'h00, 8'd9},
    {8'h10, 8'd248, 8'd250, 8'd20},
    {8'h50, 8'h35, 8'h77, 8'd143}
  };

  logic        clk = 1'b0;
  logic        reset;
  lcd_regs_t   regs;
  logic        vram_we;
  logic [12:0] vram_waddr;
  logic [7:0]  vram_wdata;
  pixel_t      pixel;
  ppu_mode_t   mode;
  logic [7:0]  ly;

  // Copy of all VRAM contents
  logic [7:0]  mirror [vram_bytes];
  integer      seed = 4;
  int          error_count = 0;
  int          errors_at_start = 0;
  int          test_count = 0;
  int          failed_tests = 0;

  always #4 clk = ~clk;

  ppu_bg_top DUT (
    .clk        (clk),
    .reset      (reset),
    .regs       (regs),
    .vram_we    (vram_we),
    .vram_waddr (vram_waddr),
    .vram_wdata (vram_wdata),
    .pixel      (pixel),
    .mode       (mode),
    .ly         (ly)
  );

  // Colour is don't care on an invalid pixel
  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got.valid !== exp.valid || (exp.valid && got.color !== exp.color)) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_mode(input string name, input ppu_mode_t got, input ppu_mode_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_ly(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic end_on_timeout(input string what);
    $display("Timeout: %s", what);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic wait_for_mode(input ppu_mode_t target, input int limit, input string what);
    int dots;
    dots = 0;
    do begin
      @(negedge clk);
      dots++;
      if (dots > limit) end_on_timeout(what);
    end while (mode != target);
  endtask

  // Horizontal or vertical blank, where registers may change
  task automatic wait_idle();
    int dots;
    dots = 0;
    do begin
      @(negedge clk);
      dots++;
      if (dots > line_dots) end_on_timeout("no blanking period within one line");
    end while (mode != ppu_mode_0 && mode != ppu_mode_1);
  endtask

  task automatic wait_line_start(input logic [7:0] line);
    int dots;
    dots = 0;
    do begin
      @(negedge clk);
      dots++;
      if (dots > frame_dots) end_on_timeout($sformatf("line %0d never started", line));
    end while (!(ly == line && mode == ppu_mode_2));
  endtask

  task automatic apply_regs(input lcd_regs_t r);
    wait_idle();
    @(posedge clk);
    regs <= r;
  endtask

  // Expected colour of screen pixel x, coarse scroll only
  function automatic gb_color_t model_color(input lcd_regs_t r, input int line, input int x);
    int bg_y;
    int map_addr;
    int id;
    int data_addr;
    logic [7:0] lo;
    logic [7:0] hi;
    bg_y = (int'(r.scy) + line) % 256;
    map_addr = (r.lcdc[6] ? 'h1C00 : 'h1800) + (bg_y / 8) * 32 + (int'(r.scx) / 8 + x / 8) % 32;
    id = mirror[map_addr];
    if (r.lcdc[4]) begin
      data_addr = id * 16;
    end else begin
      // Ids 128 and up sit below 0x1000
      if (id >= 128) id = id - 256;
      data_addr = 'h1000 + id * 16;
    end
    data_addr = data_addr + (bg_y % 8) * 2;
    lo = mirror[data_addr];
    hi = mirror[data_addr + 1];
    return {hi[7 - x % 8], lo[7 - x % 8]};
  endfunction

  task automatic capture_line(input lcd_regs_t r, input logic [7:0] line);
    int dots;
    int count;
    bit drawing;
    bit done;
    pixel_t exp;
    dots = 0;
    count = 0;
    drawing = 0;
    done = 0;
    wait_line_start(line);
    while (!done) begin
      if (pixel.valid) begin
        exp.color = model_color(r, line, count);
        exp.valid = 1'b1;
        check_pixel($sformatf("pixel line %0d x %0d", line, count), pixel, exp);
        count++;
      end
      if (mode == ppu_mode_3) begin
        drawing = 1;
      end else if (drawing) begin
        done = 1;
      end
      if (!done) begin
        @(negedge clk);
        dots++;
        if (dots > line_dots) end_on_timeout($sformatf("line %0d kept drawing", line));
      end
    end
    check_count($sformatf("pixel count line %0d", line), count, screen_width);
    check_ly("ly after drawing", ly, line);
  endtask

  task automatic report_test(input string name);
    test_count++;
    if (error_count == errors_at_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  initial begin
    logic [7:0] fill;
    lcd_regs_t  sweep_regs;
    int         assert_errors;
    reset      = 1'b1;
    regs       = '0;
    vram_we    = 1'b0;
    vram_waddr = '0;
    vram_wdata = '0;
    // VRAM filled while the PPU sits in reset
    for (int a = 0; a < vram_bytes; a++) begin
      fill = $random(seed);
      mirror[a] = fill;
      @(posedge clk);
      vram_we    <= 1'b1;
      vram_waddr <= 13'(a);
      vram_wdata <= fill;
    end
    @(posedge clk);
    vram_we <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // Reset state, then OAM scan covers dots 0 to 79
    @(negedge clk);
    check_mode("mode", mode, ppu_mode_2);
    check_ly("ly", ly, 8'd0);
    check_pixel("pixel", pixel, '0);
    repeat (79) @(negedge clk);
    check_mode("mode at dot 79", mode, ppu_mode_2);
    @(negedge clk);
    check_mode("mode at dot 80", mode, ppu_mode_3);
    wait_for_mode(ppu_mode_0, line_dots, "line 0 never left drawing");
    check_ly("ly in hblank", ly, 8'd0);
    wait_for_mode(ppu_mode_2, line_dots, "line 1 never started");
    check_ly("ly at line 1", ly, 8'd1);
    report_test("reset and mode sequence");

    foreach (scenarios[i]) begin
      apply_regs(scenarios[i].regs);
      capture_line(scenarios[i].regs, scenarios[i].line);
      report_test($sformatf("lcdc %02h scx %02h scy %02h line %0d", scenarios[i].regs.lcdc,
                            scenarios[i].regs.scx, scenarios[i].regs.scy, scenarios[i].line));
    end

    // Map 0 with signed data, every visible line
    sweep_regs = {8'h00, 8'h18, 8'hc4};
    apply_regs(sweep_regs);
    for (int l = 0; l < visible_lines; l++) begin
      capture_line(sweep_regs, 8'(l));
    end
    report_test("all visible lines");

    // Ten blank lines, no pixels, then the frame wraps
    wait_for_mode(ppu_mode_1, line_dots, "vertical blank never started");
    check_ly("ly at vblank", ly, visible_lines);
    for (int d = 0; d < 10 * line_dots; d++) begin
      if (d != 0) @(negedge clk);
      check_mode("mode in vblank", mode, ppu_mode_1);
      check_pixel("pixel in vblank", pixel, '0);
    end
    @(negedge clk);
    check_mode("mode after vblank", mode, ppu_mode_2);
    check_ly("ly after vblank", ly, 8'd0);
    report_test("vertical blank");

    assert_errors = DUT.u_fetcher.props.fail_count;
    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             test_count, failed_tests, error_count, assert_errors);
    if (failed_tests == 0 && assert_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bender.yml
package:
  name: ppu_bg

sources:
  - files:
      - verilog/ppu_regs_pkg.sv
      - verilog/ppu_pixel_pkg.sv
      - verilog/ppu_mode_timer.sv
      - verilog/ppu_vram.sv
      - verilog/ppu_bg_fetcher.sv
      - verilog/ppu_bg_fifo.sv
      - verilog/ppu_bg_top.sv
  - target: test
    files:
      - verification/ppu_bg_properties.sv
      - verification/ppu_bg_tb.sv

// File: ppu_bg.f
verilog/ppu_regs_pkg.sv
verilog/ppu_pixel_pkg.sv
verilog/ppu_mode_timer.sv
verilog/ppu_vram.sv
verilog/ppu_bg_fetcher.sv
verilog/ppu_bg_fifo.sv
verilog/ppu_bg_top.sv
verification/ppu_bg_properties.sv
verification/ppu_bg_tb.sv
